// ==== s1_dma_rd_top.f ====
rtl/s1_dma_rd_pkg.sv
rtl/s1_dma_cfg_if.sv
rtl/s1_dma_rd_regs.sv
rtl/s1_dma_op_fsm.sv
rtl/s1_dma_rd_engine.sv
rtl/s1_dma_rd_top.sv
bench/tb_src_mem.sv
bench/tb_s1_dma_rd.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status follows the run
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f s1_dma_rd_top.f \
  --top-module tb_s1_dma_rd \
  -o sim_tb_s1_dma_rd \
  && ./obj_dir/sim_tb_s1_dma_rd \
  || { echo "Simulation run failed"; exit 1; }

// ==== bench/tb_s1_dma_rd.sv ====
// Testbench for the DMA read operator with command table, exchange responders and write checker
`timescale 1ns/10ps
`default_nettype none

module tb_s1_dma_rd
  import s1_dma_rd_pkg::*;
();

  localparam int RD_DELAY = 4;
  localparam int TIMEOUT  = 2000;
  localparam int NUM_CMDS = 6;

  typedef struct packed {
    op_id_t    op_id;
    ttl_t      ttl;
    logic      pp_init;
    logic      irq_en;
    xfer_len_t len;
    src_addr_t ping_src;
    src_addr_t pong_src;
    l1_addr_t  ping_dst;
    l1_addr_t  pong_dst;
  } cmd_row_t;

  // Op id, ttl, initial buffer, irq enable, length, ping src, pong src, ping dst, pong dst
  localparam cmd_row_t CMD_TABLE [NUM_CMDS] = '{
    '{3'd3, 4'd3, 1'b0, 1'b1, 8'd5,  16'h0100, 16'h0200, 16'h1000, 16'h2000},
    '{3'd5, 4'd2, 1'b1, 1'b0, 8'd3,  16'h0340, 16'h0480, 16'h3000, 16'h3100},
    '{3'd1, 4'd0, 1'b0, 1'b1, 8'd4,  16'h0010, 16'h0020, 16'h0030, 16'h0040},
    '{3'd6, 4'd2, 1'b1, 1'b1, 8'd0,  16'h0500, 16'h0600, 16'h4000, 16'h5000},
    '{3'd7, 4'd4, 1'b0, 1'b1, 8'd12, 16'h0FF8, 16'h1234, 16'h6000, 16'h7000},
    '{3'd2, 4'd1, 1'b1, 1'b0, 8'd1,  16'h8000, 16'h9000, 16'hA000, 16'hB000}
  };

  logic      clk = 1'b0;
  logic      rst_n;
  logic      i_cfg_we;
  cfg_addr_t i_cfg_addr;
  data_t     i_cfg_wdata;
  data_t     o_cfg_rdata;
  logic      i_cmd_req;
  op_id_t    i_cmd_op_id;
  ttl_t      i_cmd_ttl;
  logic      o_cmd_ack;
  logic      i_start_req;
  logic      o_start_ack;
  logic      o_mem_req;
  logic      i_mem_ack = 1'b0;
  logic      o_finish_req;
  op_id_t    o_finish_dest_op;
  logic      o_finish_pp;
  logic      i_finish_ack = 1'b0;
  logic      o_src_rd_en;
  src_addr_t o_src_rd_addr;
  data_t     i_src_rd_data;
  logic      o_l1_wr_en;
  l1_addr_t  o_l1_wr_addr;
  data_t     o_l1_wr_data;
  logic      o_irq;

  // Expected frame context, written by the main sequence
  cmd_row_t  cur_row;
  logic      cur_pp;
  src_addr_t cur_src_base;
  l1_addr_t  cur_dst_base;
  int        frame_base;
  // Event counters, each owned by one process
  int        wr_cnt = 0;
  int        start_cnt = 0;
  int        mem_cnt = 0;
  int        fin_cnt = 0;
  // Responder delay state
  logic [7:0] mem_lfsr = 8'd73;
  logic [7:0] fin_lfsr = 8'd73;
  int         mem_wait = -1;
  int         fin_wait = -1;

  always #4 clk = ~clk;

  s1_dma_rd_top #(
    .RD_DELAY (RD_DELAY)
  ) u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_cfg_we         (i_cfg_we),
    .i_cfg_addr       (i_cfg_addr),
    .i_cfg_wdata      (i_cfg_wdata),
    .o_cfg_rdata      (o_cfg_rdata),
    .i_cmd_req        (i_cmd_req),
    .i_cmd_op_id      (i_cmd_op_id),
    .i_cmd_ttl        (i_cmd_ttl),
    .o_cmd_ack        (o_cmd_ack),
    .i_start_req      (i_start_req),
    .o_start_ack      (o_start_ack),
    .o_mem_req        (o_mem_req),
    .i_mem_ack        (i_mem_ack),
    .o_finish_req     (o_finish_req),
    .o_finish_dest_op (o_finish_dest_op),
    .o_finish_pp      (o_finish_pp),
    .i_finish_ack     (i_finish_ack),
    .o_src_rd_en      (o_src_rd_en),
    .o_src_rd_addr    (o_src_rd_addr),
    .i_src_rd_data    (i_src_rd_data),
    .o_l1_wr_en       (o_l1_wr_en),
    .o_l1_wr_addr     (o_l1_wr_addr),
    .o_l1_wr_data     (o_l1_wr_data),
    .o_irq            (o_irq)
  );

  tb_src_mem #(
    .RD_DELAY (RD_DELAY)
  ) u_src_mem (
    .clk       (clk),
    .i_rd_en   (o_src_rd_en),
    .i_rd_addr (o_src_rd_addr),
    .o_rd_data (i_src_rd_data)
  );

  // --------------------
  // Helpers
  // --------------------

  task automatic stop_on_failure();
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // Taps 8,6,5,4
  function automatic logic [7:0] lfsr_step(input logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  // Two fresh bits give 0 to 3 cycles
  task automatic draw_delay(inout logic [7:0] state, output int delay);
    state = lfsr_step(state);
    delay = int'(state[0]);
    state = lfsr_step(state);
    delay = delay + 2 * int'(state[0]);
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input data_t data);
    @(posedge clk);
    #1;
    i_cfg_we    = 1'b1;
    i_cfg_addr  = addr;
    i_cfg_wdata = data;
    @(posedge clk);
    #1;
    i_cfg_we = 1'b0;
  endtask

  // Readback is combinational, sampled on the next edge
  task automatic cfg_read(input cfg_addr_t addr, output data_t data);
    @(posedge clk);
    #1;
    i_cfg_addr = addr;
    @(posedge clk);
    data = o_cfg_rdata;
  endtask

  task automatic issue_command(input op_id_t id, input ttl_t ttl);
    int n;
    @(posedge clk);
    #1;
    i_cmd_req   = 1'b1;
    i_cmd_op_id = id;
    i_cmd_ttl   = ttl;
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      if (o_cmd_ack) break;
    end
    if (n == TIMEOUT) begin
      $display("Timeout waiting for the command acknowledge");
      stop_on_failure();
    end
    #1;
    i_cmd_req = 1'b0;
  endtask

  task automatic run_frame();
    int n;
    int fins;
    @(posedge clk);
    #1;
    // Bases of the buffer this frame should use
    cur_src_base = cur_pp ? cur_row.pong_src : cur_row.ping_src;
    cur_dst_base = cur_pp ? cur_row.pong_dst : cur_row.ping_dst;
    frame_base   = wr_cnt;
    fins         = fin_cnt;
    i_start_req  = 1'b1;
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      if (o_start_ack) break;
    end
    if (n == TIMEOUT) begin
      $display("Timeout waiting for the start acknowledge");
      stop_on_failure();
    end
    #1;
    i_start_req = 1'b0;
    // Frame ends when the finish request is taken
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      if (fin_cnt != fins) break;
    end
    if (n == TIMEOUT) begin
      $display("Timeout waiting for the frame to finish");
      stop_on_failure();
    end
    #1;
    check_value("o_l1_wr_en count", 32'(wr_cnt - frame_base), 32'(cur_row.len));
    check_value("o_irq", 32'(o_irq), 32'(cur_row.irq_en));
    cur_pp = ~cur_pp;
  endtask

  task automatic wait_cmd_done();
    int    n;
    data_t rd;
    for (n = 0; n < TIMEOUT; n++) begin
      cfg_read(REG_IRQ, rd);
      if (rd[1]) break;
    end
    if (n == TIMEOUT) begin
      $display("Timeout waiting for the command done status bit");
      stop_on_failure();
    end
  endtask

  task automatic run_command(input cmd_row_t row);
    cfg_addr_t addrs [6];
    data_t     vals [6];
    data_t     rd;
    int        starts;
    int        mems;
    int        fins;
    @(posedge clk);
    #1;
    cur_row = row;
    cur_pp  = row.pp_init;
    addrs = '{REG_CTRL, REG_PING_SRC, REG_PONG_SRC, REG_PING_DST, REG_PONG_DST, REG_LEN};
    vals  = '{{30'h0, row.irq_en, row.pp_init}, {16'h0, row.ping_src}, {16'h0, row.pong_src},
              {16'h0, row.ping_dst}, {16'h0, row.pong_dst}, {24'h0, row.len}};
    for (int i = 0; i < 6; i++) begin
      cfg_write(addrs[i], vals[i]);
      cfg_read(addrs[i], rd);
      check_value($sformatf("o_cfg_rdata at reg %0d", addrs[i]), rd, vals[i]);
    end
    // Start each command with a clean interrupt status
    cfg_write(REG_IRQ, 32'h3);
    cfg_read(REG_IRQ, rd);
    check_value("o_cfg_rdata at REG_IRQ", rd, 32'h0);
    check_value("o_irq", 32'(o_irq), 32'h0);
    starts = start_cnt;
    mems   = mem_cnt;
    fins   = fin_cnt;
    issue_command(row.op_id, row.ttl);
    for (int f = 0; f < int'(row.ttl); f++) begin
      run_frame();
    end
    wait_cmd_done();
    #1;
    check_value("o_start_ack count", 32'(start_cnt - starts), 32'(row.ttl));
    check_value("o_mem_req count", 32'(mem_cnt - mems), 32'(row.ttl));
    check_value("o_finish_req count", 32'(fin_cnt - fins), 32'(row.ttl));
    check_value("o_irq", 32'(o_irq), 32'(row.irq_en));
    // Back in IDLE with no frames left
    cfg_read(REG_STATUS, rd);
    check_value("o_cfg_rdata at REG_STATUS", rd, 32'h0);
  endtask

  // --------------------
  // Monitors and responders
  // --------------------

  // Every L1 write against the selected buffer bases
  always @(posedge clk) begin
    if (rst_n && o_l1_wr_en) begin
      check_value("o_l1_wr_addr", 32'(o_l1_wr_addr),
                  32'(cur_dst_base + l1_addr_t'(wr_cnt - frame_base)));
      check_value("o_l1_wr_data", o_l1_wr_data,
                  {16'hD0A7, src_addr_t'(cur_src_base + src_addr_t'(wr_cnt - frame_base))});
      wr_cnt++;
    end
  end

  always @(posedge clk) begin
    if (rst_n && o_start_ack) start_cnt++;
  end

  // Memory claim answered after a random delay
  always @(posedge clk) begin
    if (rst_n) begin
      if (i_mem_ack) begin
        #1;
        i_mem_ack = 1'b0;
      end else if (o_mem_req) begin
        if (mem_wait < 0) draw_delay(mem_lfsr, mem_wait);
        if (mem_wait == 0) begin
          mem_wait = -1;
          #1;
          mem_cnt++;
          i_mem_ack = 1'b1;
        end else begin
          mem_wait--;
        end
      end
    end
  end

  // Finish info checked on every held cycle
  always @(posedge clk) begin
    if (rst_n) begin
      if (i_finish_ack) begin
        #1;
        i_finish_ack = 1'b0;
      end else if (o_finish_req) begin
        check_value("o_finish_pp", 32'(o_finish_pp), 32'(cur_pp));
        check_value("o_finish_dest_op", 32'(o_finish_dest_op), 32'(cur_row.op_id));
        if (fin_wait < 0) draw_delay(fin_lfsr, fin_wait);
        if (fin_wait == 0) begin
          fin_wait = -1;
          #1;
          fin_cnt++;
          i_finish_ack = 1'b1;
        end else begin
          fin_wait--;
        end
      end
    end
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin : main_seq
    data_t rd;
    rst_n        = 1'b0;
    i_cfg_we     = 1'b0;
    i_cfg_addr   = REG_CTRL;
    i_cfg_wdata  = '0;
    i_cmd_req    = 1'b0;
    i_cmd_op_id  = '0;
    i_cmd_ttl    = '0;
    i_start_req  = 1'b0;
    cur_row      = CMD_TABLE[0];
    cur_pp       = 1'b0;
    cur_src_base = '0;
    cur_dst_base = '0;
    frame_base   = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Handshake outputs quiet after reset
    check_value("o_cmd_ack", 32'(o_cmd_ack), 32'h0);
    check_value("o_start_ack", 32'(o_start_ack), 32'h0);
    check_value("o_mem_req", 32'(o_mem_req), 32'h0);
    check_value("o_finish_req", 32'(o_finish_req), 32'h0);
    check_value("o_src_rd_en", 32'(o_src_rd_en), 32'h0);
    check_value("o_l1_wr_en", 32'(o_l1_wr_en), 32'h0);
    check_value("o_irq", 32'(o_irq), 32'h0);
    cfg_read(REG_STATUS, rd);
    check_value("o_cfg_rdata at REG_STATUS", rd, 32'h0);
    for (int c = 0; c < NUM_CMDS; c++) begin
      run_command(CMD_TABLE[c]);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_src_mem.sv ====
// Source memory model with fixed read latency and address-derived data words
`timescale 1ns/10ps
`default_nettype none

module tb_src_mem
  import s1_dma_rd_pkg::*;
#(
  // Cycles from read strobe to data
  parameter int RD_DELAY = 4
) (
  input  logic      clk,
  input  logic      i_rd_en,
  input  src_addr_t i_rd_addr,
  output data_t     o_rd_data
);

  // One stage per cycle of latency
  data_t data_pipe [RD_DELAY];

  // --------------------
  // Read pipeline
  // --------------------

  always_ff @(posedge clk) begin
    // Marker in the upper half, full word address in the lower half
    data_pipe[0] <= i_rd_en ? {16'hD0A7, i_rd_addr} : '0;
    for (int i = 1; i < RD_DELAY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  // Valid RD_DELAY cycles after the read cycle
  assign o_rd_data = data_pipe[RD_DELAY-1];

endmodule

`default_nettype wire

// ==== rtl/s1_dma_rd_top.sv ====
// Stage-one DMA read operator top level with register block, operator FSM and read engine
`timescale 1ns/10ps
`default_nettype none

module s1_dma_rd_top
  import s1_dma_rd_pkg::*;
#(
  // Source read latency in cycles
  parameter int RD_DELAY = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  // Config bus
  input  logic      i_cfg_we,
  input  cfg_addr_t i_cfg_addr,
  input  data_t     i_cfg_wdata,
  output data_t     o_cfg_rdata,
  // Command exchange
  input  logic      i_cmd_req,
  input  op_id_t    i_cmd_op_id,
  input  ttl_t      i_cmd_ttl,
  output logic      o_cmd_ack,
  // Start exchange
  input  logic      i_start_req,
  output logic      o_start_ack,
  // Memory exchange
  output logic      o_mem_req,
  input  logic      i_mem_ack,
  // Finish exchange
  output logic      o_finish_req,
  output op_id_t    o_finish_dest_op,
  output logic      o_finish_pp,
  input  logic      i_finish_ack,
  // Source memory
  output logic      o_src_rd_en,
  output src_addr_t o_src_rd_addr,
  input  data_t     i_src_rd_data,
  // L1 write
  output logic      o_l1_wr_en,
  output l1_addr_t  o_l1_wr_addr,
  output data_t     o_l1_wr_data,
  output logic      o_irq
);

  // FSM to engine
  logic       core_start;
  logic       core_pp;
  logic       core_done;
  // FSM to register block
  fsm_state_t fsm_state;
  ttl_t       ttl_left;
  logic       cmd_done;

  s1_dma_cfg_if u_cfg_if ();

  s1_dma_rd_regs u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_cfg_we     (i_cfg_we),
    .i_cfg_addr   (i_cfg_addr),
    .i_cfg_wdata  (i_cfg_wdata),
    .o_cfg_rdata  (o_cfg_rdata),
    .i_frame_done (core_done),
    .i_cmd_done   (cmd_done),
    .i_state      (fsm_state),
    .i_ttl_left   (ttl_left),
    .o_irq        (o_irq),
    .cfg          (u_cfg_if.regs)
  );

  s1_dma_op_fsm u_fsm (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_cmd_req        (i_cmd_req),
    .i_cmd_op_id      (i_cmd_op_id),
    .i_cmd_ttl        (i_cmd_ttl),
    .o_cmd_ack        (o_cmd_ack),
    .i_start_req      (i_start_req),
    .o_start_ack      (o_start_ack),
    .o_mem_req        (o_mem_req),
    .i_mem_ack        (i_mem_ack),
    .o_finish_req     (o_finish_req),
    .o_finish_dest_op (o_finish_dest_op),
    .o_finish_pp      (o_finish_pp),
    .i_finish_ack     (i_finish_ack),
    .o_core_start     (core_start),
    .o_core_pp        (core_pp),
    .i_core_done      (core_done),
    .o_state          (fsm_state),
    .o_ttl_left       (ttl_left),
    .o_cmd_done       (cmd_done),
    .cfg              (u_cfg_if.fsm)
  );

  s1_dma_rd_engine #(
    .RD_DELAY (RD_DELAY)
  ) u_engine (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (core_start),
    .i_pp          (core_pp),
    .o_done        (core_done),
    .o_src_rd_en   (o_src_rd_en),
    .o_src_rd_addr (o_src_rd_addr),
    .i_src_rd_data (i_src_rd_data),
    .o_l1_wr_en    (o_l1_wr_en),
    .o_l1_wr_addr  (o_l1_wr_addr),
    .o_l1_wr_data  (o_l1_wr_data),
    .cfg           (u_cfg_if.engine)
  );

endmodule

`default_nettype wire

// ==== rtl/s1_dma_rd_engine.sv ====
// Read address generator with an RD_DELAY deep pipeline writing source words into L1
`timescale 1ns/10ps
`default_nettype none

module s1_dma_rd_engine
  import s1_dma_rd_pkg::*;
#(
  parameter int RD_DELAY = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  // Core control
  input  logic         i_start,
  input  logic         i_pp,
  output logic         o_done,
  // Source memory read
  output logic         o_src_rd_en,
  output src_addr_t    o_src_rd_addr,
  input  data_t        i_src_rd_data,
  // L1 write
  output logic         o_l1_wr_en,
  output l1_addr_t     o_l1_wr_addr,
  output data_t        o_l1_wr_data,
  // Configuration
  s1_dma_cfg_if.engine cfg
);

  // Reads still to issue, counting the current one
  xfer_len_t           rd_left;
  l1_addr_t            dst_addr;
  logic                rd_last;
  // Per stage valid, last marker and L1 address
  logic [RD_DELAY-1:0] pipe_vld;
  logic [RD_DELAY-1:0] pipe_last;
  l1_addr_t            pipe_addr [RD_DELAY];

  assign rd_last = o_src_rd_en && (rd_left == xfer_len_t'(1));

  // --------------------
  // Read issue
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_src_rd_en <= 1'b0;
      rd_left     <= '0;
    end else if (i_start) begin
      o_src_rd_en <= (cfg.xfer_len != '0);
      rd_left     <= cfg.xfer_len;
    end else if (o_src_rd_en) begin
      o_src_rd_en <= !rd_last;
      rd_left     <= rd_left - xfer_len_t'(1);
    end
  end

  // Bases picked by buffer, then walk one word per read
  always_ff @(posedge clk) begin
    if (i_start) begin
      o_src_rd_addr <= i_pp ? cfg.pong_src : cfg.ping_src;
      dst_addr      <= i_pp ? cfg.pong_dst : cfg.ping_dst;
    end else if (o_src_rd_en) begin
      o_src_rd_addr <= o_src_rd_addr + src_addr_t'(1);
      dst_addr      <= dst_addr + l1_addr_t'(1);
    end
  end

  // --------------------
  // Latency pipeline
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_vld  <= '0;
      pipe_last <= '0;
      o_done    <= 1'b0;
    end else begin
      pipe_vld[0]  <= o_src_rd_en;
      pipe_last[0] <= rd_last;
      for (int i = 1; i < RD_DELAY; i++) begin
        pipe_vld[i]  <= pipe_vld[i-1];
        pipe_last[i] <= pipe_last[i-1];
      end
      // Done after last write, or right away for an empty frame
      o_done <= (pipe_vld[RD_DELAY-1] && pipe_last[RD_DELAY-1]) ||
                (i_start && (cfg.xfer_len == '0));
    end
  end

  always_ff @(posedge clk) begin
    pipe_addr[0] <= dst_addr;
    for (int i = 1; i < RD_DELAY; i++) begin
      pipe_addr[i] <= pipe_addr[i-1];
    end
  end

  // Data lands together with the matching address
  assign o_l1_wr_en   = pipe_vld[RD_DELAY-1];
  assign o_l1_wr_addr = pipe_addr[RD_DELAY-1];
  assign o_l1_wr_data = i_src_rd_data;

  // New frame only once the previous one has drained
  a_start_drained: assert property (@(posedge clk) disable iff (!rst_n)
    i_start |-> !o_src_rd_en && (pipe_vld == '0));

endmodule

`default_nettype wire

// ==== rtl/s1_dma_op_fsm.sv ====
// Operator FSM for command, start, memory and finish exchanges with frame count and ping-pong
`timescale 1ns/10ps
`default_nettype none

module s1_dma_op_fsm
  import s1_dma_rd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Command
  input  logic       i_cmd_req,
  input  op_id_t     i_cmd_op_id,
  input  ttl_t       i_cmd_ttl,
  output logic       o_cmd_ack,
  // Start
  input  logic       i_start_req,
  output logic       o_start_ack,
  // Memory claim
  output logic       o_mem_req,
  input  logic       i_mem_ack,
  // Finish
  output logic       o_finish_req,
  output op_id_t     o_finish_dest_op,
  output logic       o_finish_pp,
  input  logic       i_finish_ack,
  // Core
  output logic       o_core_start,
  output logic       o_core_pp,
  input  logic       i_core_done,
  // Status
  output fsm_state_t o_state,
  output ttl_t       o_ttl_left,
  output logic       o_cmd_done,
  // Configuration
  s1_dma_cfg_if.fsm  cfg
);

  fsm_state_t state;
  ttl_t       ttl_left;
  // Current buffer, 1 is pong
  logic       pp;
  op_id_t     op_id;

  // --------------------
  // Main FSM
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= IDLE;
      ttl_left     <= '0;
      pp           <= 1'b0;
      o_cmd_ack    <= 1'b0;
      o_start_ack  <= 1'b0;
      o_mem_req    <= 1'b0;
      o_core_start <= 1'b0;
      o_finish_req <= 1'b0;
      o_cmd_done   <= 1'b0;
    end else begin
      // Pulses default low
      o_cmd_ack    <= 1'b0;
      o_start_ack  <= 1'b0;
      o_core_start <= 1'b0;
      o_cmd_done   <= 1'b0;
      case (state)
        IDLE: begin
          if (o_cmd_ack) begin
            // Ack cycle, requester drops its level now
            if (ttl_left != '0) state <= WAIT_START;
          end else if (i_cmd_req) begin
            o_cmd_ack  <= 1'b1;
            ttl_left   <= i_cmd_ttl;
            pp         <= cfg.ping_pong_init;
            // Empty command finishes on the spot
            o_cmd_done <= (i_cmd_ttl == '0);
          end
        end
        WAIT_START: begin
          if (o_start_ack) begin
            state     <= MEM_REQ;
            o_mem_req <= 1'b1;
          end else if (i_start_req) begin
            o_start_ack <= 1'b1;
          end
        end
        MEM_REQ: begin
          if (i_mem_ack) begin
            o_mem_req    <= 1'b0;
            o_core_start <= 1'b1;
            state        <= RUN;
          end
        end
        RUN: begin
          if (i_core_done) begin
            o_finish_req <= 1'b1;
            state        <= FINISH;
          end
        end
        FINISH: begin
          // Frame ends on finish accept
          if (i_finish_ack) begin
            o_finish_req <= 1'b0;
            pp           <= ~pp;
            ttl_left     <= ttl_left - ttl_t'(1);
            if (ttl_left == ttl_t'(1)) begin
              state      <= IDLE;
              o_cmd_done <= 1'b1;
            end else begin
              state <= WAIT_START;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Destination id rides along, only meaningful with finish req
  always_ff @(posedge clk) begin
    if ((state == IDLE) && !o_cmd_ack && i_cmd_req) op_id <= i_cmd_op_id;
  end

  assign o_finish_dest_op = op_id;
  assign o_finish_pp      = pp;
  assign o_core_pp        = pp;
  assign o_state          = state;
  assign o_ttl_left       = ttl_left;

  // Engine kick is one cycle wide
  a_core_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    o_core_start |=> !o_core_start);

  // Finish level held until partner acks
  a_finish_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_finish_req && !i_finish_ack |=> o_finish_req);

endmodule

`default_nettype wire

// ==== rtl/s1_dma_rd_regs.sv ====
// Configuration register file, interrupt status with write-one-to-clear, status readback
`timescale 1ns/10ps
`default_nettype none

module s1_dma_rd_regs
  import s1_dma_rd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Register access
  input  logic       i_cfg_we,
  input  cfg_addr_t  i_cfg_addr,
  input  data_t      i_cfg_wdata,
  output data_t      o_cfg_rdata,
  // Events from FSM and engine
  input  logic       i_frame_done,
  input  logic       i_cmd_done,
  // Status
  input  fsm_state_t i_state,
  input  ttl_t       i_ttl_left,
  // Interrupt
  output logic       o_irq,
  // Configuration out
  s1_dma_cfg_if.regs cfg
);

  // Bit 1 command done, bit 0 frame done
  logic [1:0] irq_status;
  logic [1:0] irq_clr;
  logic [1:0] irq_set;

  // --------------------
  // Config writes
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.ping_pong_init <= 1'b0;
      cfg.irq_en         <= 1'b0;
      cfg.ping_src       <= '0;
      cfg.pong_src       <= '0;
      cfg.ping_dst       <= '0;
      cfg.pong_dst       <= '0;
      cfg.xfer_len       <= '0;
    end else if (i_cfg_we) begin
      case (i_cfg_addr)
        REG_CTRL: begin
          cfg.ping_pong_init <= i_cfg_wdata[0];
          cfg.irq_en         <= i_cfg_wdata[1];
        end
        REG_PING_SRC: cfg.ping_src <= i_cfg_wdata[15:0];
        REG_PONG_SRC: cfg.pong_src <= i_cfg_wdata[15:0];
        REG_PING_DST: cfg.ping_dst <= i_cfg_wdata[15:0];
        REG_PONG_DST: cfg.pong_dst <= i_cfg_wdata[15:0];
        REG_LEN:      cfg.xfer_len <= i_cfg_wdata[7:0];
        // IRQ is handled below and STATUS is read only
        default: ;
      endcase
    end
  end

  // --------------------
  // Interrupt status
  // --------------------

  assign irq_clr = (i_cfg_we && (i_cfg_addr == REG_IRQ)) ? i_cfg_wdata[1:0] : 2'b00;
  assign irq_set = {i_cmd_done, i_frame_done};

  // Set after clear so an event in the clear cycle survives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_status <= 2'b00;
    end else begin
      irq_status <= (irq_status & ~irq_clr) | irq_set;
    end
  end

  assign o_irq = cfg.irq_en && (irq_status != 2'b00);

  // --------------------
  // Readback
  // --------------------

  always_comb begin
    case (i_cfg_addr)
      REG_CTRL:     o_cfg_rdata = {30'h0, cfg.irq_en, cfg.ping_pong_init};
      REG_PING_SRC: o_cfg_rdata = {16'h0, cfg.ping_src};
      REG_PONG_SRC: o_cfg_rdata = {16'h0, cfg.pong_src};
      REG_PING_DST: o_cfg_rdata = {16'h0, cfg.ping_dst};
      REG_PONG_DST: o_cfg_rdata = {16'h0, cfg.pong_dst};
      REG_LEN:      o_cfg_rdata = {24'h0, cfg.xfer_len};
      REG_IRQ:      o_cfg_rdata = {30'h0, irq_status};
      // Frames left over FSM state
      default:      o_cfg_rdata = {24'h0, i_ttl_left, 1'b0, i_state};
    endcase
  end

  // Interrupt only rises after an event or a control write
  a_irq_rise_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_irq) |->
      $past(i_frame_done || i_cmd_done || (i_cfg_we && (i_cfg_addr == REG_CTRL))));

endmodule

`default_nettype wire

// ==== rtl/s1_dma_cfg_if.sv ====
// Configuration bundle from the register block to the operator FSM and the read engine
`timescale 1ns/10ps
`default_nettype none

interface s1_dma_cfg_if import s1_dma_rd_pkg::*; ();

  // Buffer loaded on command accept
  logic      ping_pong_init;
  logic      irq_en;
  // Ping and pong base addresses
  src_addr_t ping_src;
  src_addr_t pong_src;
  l1_addr_t  ping_dst;
  l1_addr_t  pong_dst;
  // Words per frame
  xfer_len_t xfer_len;

  // Register block owns every field
  modport regs (
    output ping_pong_init, irq_en, ping_src, pong_src, ping_dst, pong_dst, xfer_len
  );

  // FSM only needs the start buffer
  modport fsm (input ping_pong_init);

  // Engine takes the bases and the length
  modport engine (input ping_src, pong_src, ping_dst, pong_dst, xfer_len);

endinterface

`default_nettype wire

// ==== rtl/s1_dma_rd_pkg.sv ====
// Width typedefs, operator state enum and register map for the stage-one DMA read operator
`default_nettype none

package s1_dma_rd_pkg;

  // --------------------
  // Widths with a meaning
  // --------------------

  // L1 word address
  typedef logic [15:0] l1_addr_t;
  // Source memory word address
  typedef logic [15:0] src_addr_t;
  // Data word on both memories and the config bus
  typedef logic [31:0] data_t;
  // Words per frame, zero means an empty frame
  typedef logic [7:0]  xfer_len_t;
  // Frames per command
  typedef logic [3:0]  ttl_t;
  // Destination operator id
  typedef logic [2:0]  op_id_t;
  // Register address
  typedef logic [2:0]  cfg_addr_t;

  // Operator FSM states
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    WAIT_START = 3'd1,
    MEM_REQ    = 3'd2,
    RUN        = 3'd3,
    FINISH     = 3'd4
  } fsm_state_t;

  // --------------------
  // Register map
  // --------------------

  // Bit 0 initial buffer (pong when set), bit 1 irq enable
  localparam cfg_addr_t REG_CTRL     = 3'd0;
  localparam cfg_addr_t REG_PING_SRC = 3'd1;
  localparam cfg_addr_t REG_PONG_SRC = 3'd2;
  localparam cfg_addr_t REG_PING_DST = 3'd3;
  localparam cfg_addr_t REG_PONG_DST = 3'd4;
  localparam cfg_addr_t REG_LEN      = 3'd5;
  // Bit 0 frame done, bit 1 command done, write one to clear
  localparam cfg_addr_t REG_IRQ      = 3'd6;
  // Read only, state in 2:0 and frames left in 7:4
  localparam cfg_addr_t REG_STATUS   = 3'd7;

endpackage

`default_nettype wire
